// File: design/ecc_arith_pkg.sv
// Field arithmetic types, opcodes and latencies for the exponentiation engine
package ecc_arith_pkg;

    // ------------------------------------------------
    // Field and scalar
    // ------------------------------------------------
    localparam int FIELD_W     = 16;
    localparam int SCALAR_BITS = 16;    // Ladder rounds

    typedef logic [FIELD_W-1:0]     felem_t;
    typedef logic [SCALAR_BITS-1:0] scalar_t;
    typedef logic [2:0]             reg_addr_t;
    typedef logic [7:0]             delay_t;

    localparam felem_t FIELD_P = 16'd65521;    // Largest 16-bit prime

    // ------------------------------------------------
    // ALU and host commands
    // ------------------------------------------------
    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_MUL = 3'd3
    } alu_op_t;

    localparam int ADD_DELAY = 1;
    localparam int MUL_DELAY = FIELD_W + 1;    // Load cycle plus one step per bit

    typedef enum logic [1:0] {
        CMD_NONE      = 2'd0,
        CMD_EXP       = 2'd1,
        CMD_EXP_SCALE = 2'd2
    } cmd_t;

    // Cycles from issue until the result may be written back
    function automatic delay_t op_latency(alu_op_t op);
        case (op)
            ALU_ADD, ALU_SUB: return delay_t'(ADD_DELAY);
            ALU_MUL:          return delay_t'(MUL_DELAY);
            default:          return '0;
        endcase
    endfunction

endpackage

// File: design/ecc_uop_pkg.sv
// Micro-instruction format, program labels and register map of the ladder controller
package ecc_uop_pkg;

    localparam int PROG_ADDR_W = 6;

    typedef logic [PROG_ADDR_W-1:0] prog_addr_t;
    typedef logic [15:0]            uinstr_t;

    // Bit positions inside a line
    localparam int UI_STALL = 15;
    localparam int UI_OP    = 12;    // 3 bits
    localparam int UI_WR    = 11;
    localparam int UI_SRC_A = 8;     // 3 bits
    localparam int UI_SRC_B = 5;     // 3 bits
    localparam int UI_DST   = 2;     // 3 bits
    localparam int UI_SWAP  = 1;

    // ------------------------------------------------
    // Program labels
    // ------------------------------------------------
    localparam prog_addr_t NOP     = 6'd0;
    localparam prog_addr_t INIT_S  = 6'd1;
    localparam prog_addr_t INIT_E  = 6'd3;
    localparam prog_addr_t LAD0_S  = 6'd4;
    localparam prog_addr_t LAD0_E  = 6'd5;
    localparam prog_addr_t LAD1_S  = 6'd6;
    localparam prog_addr_t LAD1_E  = 6'd7;
    localparam prog_addr_t SCALE_S = 6'd8;
    localparam prog_addr_t SCALE_E = 6'd9;

    // Register map
    localparam ecc_arith_pkg::reg_addr_t R_BASE = 3'd0;
    localparam ecc_arith_pkg::reg_addr_t R_FACT = 3'd1;
    localparam ecc_arith_pkg::reg_addr_t R_ONE  = 3'd2;
    localparam ecc_arith_pkg::reg_addr_t R_L0   = 3'd4;
    localparam ecc_arith_pkg::reg_addr_t R_L1   = 3'd5;
    localparam ecc_arith_pkg::reg_addr_t R_RES  = 3'd7;

    // Arithmetic line with write-back
    function automatic uinstr_t uop(ecc_arith_pkg::alu_op_t op, ecc_arith_pkg::reg_addr_t src_a,
                                    ecc_arith_pkg::reg_addr_t src_b, ecc_arith_pkg::reg_addr_t dst,
                                    logic swap);
        return {1'b0, op, 1'b1, src_a, src_b, dst, swap, 1'b0};
    endfunction

    function automatic uinstr_t ustall(logic [7:0] cycles);
        return {1'b1, 7'd0, cycles};
    endfunction

endpackage

// File: design/ecc_sequencer.sv
// Micro-instruction ROM holding the Montgomery ladder program
`timescale 1ns/1ps

module ecc_sequencer (
    input  logic                    clk,
    input  ecc_uop_pkg::prog_addr_t addr_i,
    output ecc_uop_pkg::uinstr_t    line_o
);
    import ecc_arith_pkg::*;
    import ecc_uop_pkg::*;

    // Registered read, one cycle from address to line
    always_ff @(posedge clk) begin
        case (addr_i)
            // ------------------------------------------------
            // Init: L0 = 1, L1 = base
            // ------------------------------------------------
            INIT_S:             line_o <= ustall(8'd2);
            INIT_S + 6'd1:      line_o <= uop(ALU_MUL, R_ONE, R_ONE, R_L0, 1'b0);
            INIT_E:             line_o <= uop(ALU_MUL, R_BASE, R_ONE, R_L1, 1'b0);

            // ------------------------------------------------
            // Ladder round, digit 0
            // ------------------------------------------------
            LAD0_S:             line_o <= uop(ALU_MUL, R_L0, R_L1, R_L1, 1'b0);
            LAD0_E:             line_o <= uop(ALU_MUL, R_L0, R_L0, R_L0, 1'b0);

            // Same round with L0 and L1 traded by the controller
            LAD1_S:             line_o <= uop(ALU_MUL, R_L0, R_L1, R_L1, 1'b1);
            LAD1_E:             line_o <= uop(ALU_MUL, R_L0, R_L0, R_L0, 1'b1);

            // ------------------------------------------------
            // Scale tail and result copy
            // ------------------------------------------------
            SCALE_S:            line_o <= uop(ALU_MUL, R_L0, R_FACT, R_L0, 1'b0);
            SCALE_E:            line_o <= uop(ALU_MUL, R_L0, R_ONE, R_RES, 1'b0);

            default:            line_o <= '0;    // NOP
        endcase
    end

endmodule

// File: design/ecc_ctrl.sv
// Program counter FSM driving the ladder microprogram with host handshake and stalls
`timescale 1ns/1ps

module ecc_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      cmd_req_i,
    input  ecc_arith_pkg::cmd_t       cmd_i,
    output logic                      cmd_ack_o,
    output logic                      busy_o,
    output ecc_uop_pkg::prog_addr_t   prog_addr_o,
    input  ecc_uop_pkg::uinstr_t      prog_line_i,
    input  logic                      digit_i,
    output logic                      req_digit_o,
    output ecc_arith_pkg::alu_op_t    alu_op_o,
    output ecc_arith_pkg::reg_addr_t  src_a_o,
    output ecc_arith_pkg::reg_addr_t  src_b_o,
    output ecc_arith_pkg::reg_addr_t  dst_o,
    output logic                      wr_en_o,
    output logic                      load_o
);
    import ecc_arith_pkg::*;
    import ecc_uop_pkg::*;

    localparam int LAD_W = $clog2(SCALAR_BITS + 1);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE, S_REL} state_t;

    state_t           state;
    prog_addr_t       prog_cntr;
    cmd_t             cmd_q;
    logic [LAD_W-1:0] ladder_cntr;    // Rounds still to branch into
    delay_t           delay_cntr;
    logic             line_ok;        // ROM output belongs to prog_cntr
    logic             issued;         // Current line sits in the issue stage
    logic             wr_pend;        // Write-back stage waiting on the ALU
    logic             cmd_ok;
    alu_op_t          line_op;
    logic             line_sw;

    // Dual-ended swap, sources and destination alike
    function automatic reg_addr_t swap_addr(reg_addr_t a, logic sw);
        if (sw && (a == R_L0 || a == R_L1))
            return a ^ reg_addr_t'(1);
        return a;
    endfunction

    assign line_op     = alu_op_t'(prog_line_i[UI_OP +: 3]);
    assign line_sw     = prog_line_i[UI_SWAP];
    assign cmd_ok      = (cmd_i == CMD_EXP) || (cmd_i == CMD_EXP_SCALE);
    assign load_o      = (state == S_IDLE) && cmd_req_i && cmd_ok;    // Operands latched here
    assign prog_addr_o = prog_cntr;
    assign busy_o      = (state == S_RUN);
    assign cmd_ack_o   = (state == S_DONE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= S_IDLE;
            prog_cntr   <= NOP;
            cmd_q       <= CMD_NONE;
            ladder_cntr <= '0;
            delay_cntr  <= '0;
            line_ok     <= 1'b0;
            issued      <= 1'b0;
            wr_pend     <= 1'b0;
            req_digit_o <= 1'b0;
            alu_op_o    <= ALU_NOP;
            src_a_o     <= '0;
            src_b_o     <= '0;
            dst_o       <= '0;
            wr_en_o     <= 1'b0;
        end else begin
            req_digit_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (load_o) begin
                        cmd_q       <= cmd_i;
                        ladder_cntr <= LAD_W'(SCALAR_BITS);
                        prog_cntr   <= INIT_S;
                        state       <= S_RUN;
                    end
                end

                S_RUN: begin
                    if (!line_ok) begin
                        line_ok <= 1'b1;                      // ROM read in flight
                    end else if (!issued) begin
                        issued <= 1'b1;
                        if (prog_line_i[UI_STALL]) begin
                            delay_cntr <= prog_line_i[7:0];
                            wr_pend    <= 1'b0;
                        end else begin
                            delay_cntr <= op_latency(line_op);
                            alu_op_o   <= line_op;
                            src_a_o    <= swap_addr(prog_line_i[UI_SRC_A +: 3], line_sw);
                            src_b_o    <= swap_addr(prog_line_i[UI_SRC_B +: 3], line_sw);
                            dst_o      <= swap_addr(prog_line_i[UI_DST +: 3], line_sw);
                            wr_pend    <= prog_line_i[UI_WR];
                        end
                    end else if (delay_cntr != 0) begin
                        // Program counter held while the op runs
                        alu_op_o   <= ALU_NOP;
                        delay_cntr <= delay_cntr - 1'b1;
                        wr_en_o    <= wr_pend && (delay_cntr == 1);
                    end else begin
                        wr_en_o <= 1'b0;
                        issued  <= 1'b0;
                        line_ok <= 1'b0;
                        case (prog_cntr)
                            INIT_E, LAD0_E, LAD1_E: begin
                                if (ladder_cntr == 0) begin
                                    // Ladder finished, scale only for command 2
                                    prog_cntr <= (cmd_q == CMD_EXP_SCALE) ? SCALE_S : SCALE_E;
                                end else begin
                                    ladder_cntr <= ladder_cntr - 1'b1;
                                    req_digit_o <= 1'b1;
                                    prog_cntr   <= digit_i ? LAD1_S : LAD0_S;
                                end
                            end
                            SCALE_E: begin
                                prog_cntr <= NOP;
                                state     <= S_DONE;
                            end
                            default: prog_cntr <= prog_cntr + 1'b1;
                        endcase
                    end
                end

                S_DONE:  if (!cmd_req_i) state <= S_REL;    // Ack held until req drops
                S_REL:   state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: design/scalar_digit_reg.sv
// Scalar shift register handing out one digit per request, MSB first
`timescale 1ns/1ps

module scalar_digit_reg (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   load_i,
    input  ecc_arith_pkg::scalar_t scalar_i,
    input  logic                   req_digit_i,
    output logic                   digit_o
);
    import ecc_arith_pkg::*;

    scalar_t shift_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift_q <= '0;
        end else if (load_i) begin
            shift_q <= scalar_i;
        end else if (req_digit_i) begin
            shift_q <= {shift_q[SCALAR_BITS-2:0], 1'b0};    // Next bit to the top
        end
    end

    assign digit_o = shift_q[SCALAR_BITS-1];

endmodule

// File: design/field_alu.sv
// Field ALU with modular add, subtract and bit-serial multiply
`timescale 1ns/1ps

module field_alu (
    input  logic                   clk,
    input  logic                   reset_n,
    input  ecc_arith_pkg::alu_op_t op_i,
    input  ecc_arith_pkg::felem_t  a_i,
    input  ecc_arith_pkg::felem_t  b_i,
    output ecc_arith_pkg::felem_t  result_o
);
    import ecc_arith_pkg::*;

    localparam int CNT_W = $clog2(FIELD_W + 1);

    logic [CNT_W-1:0] bit_cntr;    // Multiply steps left
    felem_t           mul_a;
    felem_t           mul_b;       // Shifted left, MSB consumed first
    felem_t           dbl;
    felem_t           step;

    function automatic felem_t mod_add(felem_t x, felem_t y);
        logic [FIELD_W:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        if (sum >= {1'b0, FIELD_P})
            sum = sum - {1'b0, FIELD_P};
        return sum[FIELD_W-1:0];
    endfunction

    function automatic felem_t mod_sub(felem_t x, felem_t y);
        felem_t diff;
        diff = x - y;
        if (x < y)
            diff = diff + FIELD_P;    // Wraps back below p
        return diff;
    endfunction

    // One double-and-add step, reduced each time
    assign dbl  = mod_add(result_o, result_o);
    assign step = mul_b[FIELD_W-1] ? mod_add(dbl, mul_a) : dbl;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            bit_cntr <= '0;
        else if (bit_cntr != 0)
            bit_cntr <= bit_cntr - 1'b1;
        else if (op_i == ALU_MUL)
            bit_cntr <= CNT_W'(FIELD_W);
    end

    always_ff @(posedge clk) begin
        if (bit_cntr != 0) begin
            result_o <= step;
            mul_b    <= mul_b << 1;
        end else begin
            case (op_i)
                ALU_ADD: result_o <= mod_add(a_i, b_i);
                ALU_SUB: result_o <= mod_sub(a_i, b_i);
                ALU_MUL: begin
                    result_o <= '0;    // Accumulator start
                    mul_a    <= a_i;
                    mul_b    <= b_i;
                end
                default: result_o <= result_o;
            endcase
        end
    end

endmodule

// File: design/operand_regfile.sv
// Eight-entry operand memory with two read ports, one write port and host load
`timescale 1ns/1ps

module operand_regfile (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     load_i,
    input  ecc_arith_pkg::felem_t    base_i,
    input  ecc_arith_pkg::felem_t    factor_i,
    input  ecc_arith_pkg::reg_addr_t rd_a_i,
    input  ecc_arith_pkg::reg_addr_t rd_b_i,
    input  ecc_arith_pkg::reg_addr_t wr_addr_i,
    input  logic                     wr_en_i,
    input  ecc_arith_pkg::felem_t    wr_data_i,
    output ecc_arith_pkg::felem_t    rd_a_o,
    output ecc_arith_pkg::felem_t    rd_b_o,
    output ecc_arith_pkg::felem_t    result_o
);
    import ecc_arith_pkg::*;
    import ecc_uop_pkg::*;

    felem_t mem [8];

    always_ff @(posedge clk) begin
        if (load_i) begin
            mem[R_BASE] <= base_i;
            mem[R_FACT] <= factor_i;
            mem[R_ONE]  <= felem_t'(1);
        end else if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Copy of R_RES kept for the host port
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            result_o <= '0;
        else if (wr_en_i && (wr_addr_i == R_RES))
            result_o <= wr_data_i;
    end

    assign rd_a_o = mem[rd_a_i];
    assign rd_b_o = mem[rd_b_i];

endmodule

// File: design/ecc_top.sv
// Modular exponentiation engine top level, controller with its datapath
`timescale 1ns/1ps

module ecc_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   cmd_req_i,
    input  ecc_arith_pkg::cmd_t    cmd_i,
    input  ecc_arith_pkg::felem_t  base_i,
    input  ecc_arith_pkg::scalar_t scalar_i,
    input  ecc_arith_pkg::felem_t  factor_i,
    output logic                   cmd_ack_o,
    output logic                   busy_o,
    output ecc_arith_pkg::felem_t  result_o
);
    import ecc_arith_pkg::*;
    import ecc_uop_pkg::*;

    prog_addr_t prog_addr;
    uinstr_t    prog_line;
    logic       digit;
    logic       req_digit;
    logic       load;
    logic       wr_en;
    alu_op_t    alu_op;
    reg_addr_t  src_a;
    reg_addr_t  src_b;
    reg_addr_t  dst;
    felem_t     rd_a;
    felem_t     rd_b;
    felem_t     alu_result;

    ecc_ctrl u_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd_req_i  (cmd_req_i),
        .cmd_i      (cmd_i),
        .cmd_ack_o  (cmd_ack_o),
        .busy_o     (busy_o),
        .prog_addr_o(prog_addr),
        .prog_line_i(prog_line),
        .digit_i    (digit),
        .req_digit_o(req_digit),
        .alu_op_o   (alu_op),
        .src_a_o    (src_a),
        .src_b_o    (src_b),
        .dst_o      (dst),
        .wr_en_o    (wr_en),
        .load_o     (load)
    );

    ecc_sequencer u_sequencer (
        .clk   (clk),
        .addr_i(prog_addr),
        .line_o(prog_line)
    );

    scalar_digit_reg u_scalar (
        .clk        (clk),
        .reset_n    (reset_n),
        .load_i     (load),
        .scalar_i   (scalar_i),
        .req_digit_i(req_digit),
        .digit_o    (digit)
    );

    field_alu u_alu (
        .clk     (clk),
        .reset_n (reset_n),
        .op_i    (alu_op),
        .a_i     (rd_a),
        .b_i     (rd_b),
        .result_o(alu_result)
    );

    operand_regfile u_regfile (
        .clk      (clk),
        .reset_n  (reset_n),
        .load_i   (load),
        .base_i   (base_i),
        .factor_i (factor_i),
        .rd_a_i   (src_a),
        .rd_b_i   (src_b),
        .wr_addr_i(dst),
        .wr_en_i  (wr_en),
        .wr_data_i(alu_result),
        .rd_a_o   (rd_a),
        .rd_b_o   (rd_b),
        .result_o (result_o)
    );

endmodule

// File: testbench/tb_clk_gen.sv
// Testbench clock source, free-running with a 20 ns period
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);
    localparam realtime HALF_PERIOD = 10ns;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

// File: testbench/tb_ecc_top.sv
// Testbench for the exponentiation engine, file cases plus seeded random cases
`timescale 1ns/1ps

module tb_ecc_top;
    import ecc_arith_pkg::*;

    localparam int NUM_RANDOM   = 6;
    localparam int CASE_CYCLES  = SCALAR_BITS * (2 * MUL_DELAY + 16);    // Upper bound per case
    localparam int MARGIN       = 2000;                                 // Reset and handshakes

    logic    clk;
    logic    reset_n;
    logic    cmd_req;
    cmd_t    cmd;
    felem_t  base;
    scalar_t scalar;
    felem_t  factor;
    logic    cmd_ack;
    logic    busy;
    felem_t  result;

    // Case table, file lines first and random ones after
    logic [1:0] case_cmd[$];
    felem_t     case_base[$];
    scalar_t    case_scalar[$];
    felem_t     case_factor[$];
    felem_t     case_expect[$];

    int cycle_cnt;
    int timeout_limit;
    int seed;

    tb_clk_gen u_clk_gen (
        .clk_o(clk)
    );

    ecc_top u_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .cmd_req_i(cmd_req),
        .cmd_i    (cmd),
        .base_i   (base),
        .scalar_i (scalar),
        .factor_i (factor),
        .cmd_ack_o(cmd_ack),
        .busy_o   (busy),
        .result_o (result)
    );

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            $display("Timeout: no acknowledge within %0d cycles", timeout_limit);
            $display("Verification failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "Run stopped at the first mismatch");
        end
    endtask

    // Square-and-multiply, LSB first
    function automatic felem_t pow_mod(felem_t b, scalar_t e);
        logic [31:0] acc;
        logic [31:0] sq;
        int          i;
        acc = 32'd1;
        sq  = b % FIELD_P;
        for (i = 0; i < SCALAR_BITS; i++) begin
            if (e[i])
                acc = (acc * sq) % FIELD_P;
            sq = (sq * sq) % FIELD_P;
        end
        return felem_t'(acc);
    endfunction

    // --------------------------------------------------
    // Case table setup
    // --------------------------------------------------
    task automatic read_cases();
        int               fd;
        int               n;
        logic [8*96-1:0]  line;
        logic [31:0]      f_cmd;
        logic [31:0]      f_base;
        logic [31:0]      f_scalar;
        logic [31:0]      f_factor;
        logic [31:0]      f_expect;
        fd = $fopen("testbench/ecc_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file testbench/ecc_cases.txt");
            $display("Verification failed");
            $fatal(1, "No stimulus");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n    = $fgets(line, fd);
                // Comment and blank lines do not parse as five hex fields
                if (n > 0 && $sscanf(line, "%h %h %h %h %h", f_cmd, f_base, f_scalar,
                                     f_factor, f_expect) == 5) begin
                    case_cmd.push_back(f_cmd[1:0]);
                    case_base.push_back(felem_t'(f_base));
                    case_scalar.push_back(scalar_t'(f_scalar));
                    case_factor.push_back(felem_t'(f_factor));
                    case_expect.push_back(felem_t'(f_expect));
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic add_random_cases();
        int          k;
        felem_t      r_base;
        scalar_t     r_scalar;
        felem_t      r_factor;
        logic [31:0] r_expect;
        for (k = 0; k < NUM_RANDOM; k++) begin
            r_base   = felem_t'({$random(seed)} % FIELD_P);
            r_scalar = scalar_t'($random(seed));
            r_factor = felem_t'({$random(seed)} % FIELD_P);
            r_expect = pow_mod(r_base, r_scalar);
            if (k % 2 == 1)
                r_expect = (r_expect * r_factor) % FIELD_P;    // Scaled variant
            case_cmd.push_back((k % 2 == 1) ? 2'd2 : 2'd1);
            case_base.push_back(r_base);
            case_scalar.push_back(r_scalar);
            case_factor.push_back(r_factor);
            case_expect.push_back(felem_t'(r_expect));
        end
    endtask

    // --------------------------------------------------
    // One full four-phase transaction
    // --------------------------------------------------
    task automatic run_case(input int idx);
        int hold;
        @(negedge clk);
        cmd    = cmd_t'(case_cmd[idx]);
        base   = case_base[idx];
        scalar = case_scalar[idx];
        factor = case_factor[idx];
        check_value("cmd_ack_o", cmd_ack, 1'b0);    // No ack before req
        check_value("busy_o", busy, 1'b0);
        @(negedge clk);
        cmd_req = 1'b1;
        @(negedge clk);
        check_value("busy_o", busy, 1'b1);
        while (!cmd_ack) begin
            check_value("busy_o", busy, 1'b1);
            @(negedge clk);
        end
        check_value("busy_o", busy, 1'b0);
        check_value("result_o", result, case_expect[idx]);
        // Req held past ack
        for (hold = 0; hold < 3; hold++) begin
            @(negedge clk);
            check_value("cmd_ack_o", cmd_ack, 1'b1);
            check_value("busy_o", busy, 1'b0);
        end
        cmd_req = 1'b0;
        @(negedge clk);
        check_value("cmd_ack_o", cmd_ack, 1'b0);
        $display("Case %0d: cmd %0d base %h scalar %h factor %h result %h", idx,
                 case_cmd[idx], case_base[idx], case_scalar[idx], case_factor[idx], result);
    endtask

    initial begin
        int idx;
        cycle_cnt     = 0;
        timeout_limit = MARGIN;
        seed          = 32'h1543_8fdb;
        reset_n       = 1'b0;
        cmd_req       = 1'b0;
        cmd           = CMD_NONE;
        base          = '0;
        scalar        = '0;
        factor        = '0;

        read_cases();
        add_random_cases();
        timeout_limit = case_cmd.size() * CASE_CYCLES + MARGIN;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_value("cmd_ack_o", cmd_ack, 1'b0);
        check_value("busy_o", busy, 1'b0);

        // Back to back, no reset in between
        for (idx = 0; idx < case_cmd.size(); idx++)
            run_case(idx);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: testbench/ecc_cases.txt
# Columns in hex: cmd base scalar factor expected, modulus 65521
# cmd 1 gives base^scalar, cmd 2 gives base^scalar * factor
1 0002 0000 0000 0001
1 0002 0001 0000 0002
1 0002 0010 0000 000f
1 0003 000a 0000 e6a9
1 0002 ffff 0000 8000
1 fff0 ffff 0000 fff0
1 0000 0005 0000 0000
1 0001 beef 0000 0001
2 0002 0010 0003 002d
2 0003 000a 0000 0000
2 0003 000a fff0 1948
2 0000 0009 1234 0000
2 0001 0003 1234 1234
2 0005 0000 00ff 00ff

// File: verilog.f
design/ecc_arith_pkg.sv
design/ecc_uop_pkg.sv
design/ecc_sequencer.sv
design/ecc_ctrl.sv
design/scalar_digit_reg.sv
design/field_alu.sv
design/operand_regfile.sv
design/ecc_top.sv
testbench/tb_clk_gen.sv
testbench/tb_ecc_top.sv

// File: Bender.yml
package:
  name: ecc_ladder

sources:
  - design/ecc_arith_pkg.sv
  - design/ecc_uop_pkg.sv
  - design/ecc_sequencer.sv
  - design/ecc_ctrl.sv
  - design/scalar_digit_reg.sv
  - design/field_alu.sv
  - design/operand_regfile.sv
  - design/ecc_top.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_ecc_top.sv
